// File: compile.f
+incdir+include
src/pc_check_pkg.sv
src/pc_trace_router.sv
src/pc_check_lane.sv
src/pc_err_collector.sv
src/pc_check_top.sv
tb/pc_check_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the PC check testbench with Verilator, run it and judge the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module pc_check_tb -f compile.f \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vpc_check_tb)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Simulation finished: PASS" \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }

// File: tb/pc_check_testdata.txt
# grp en hart kind a b pc target exp (kind 0 seq 1 jump 2 branch 3 trap 4 mret 5 csr)
# a is compressed or csr_sel, b is taken, csr value sits in target, exp 0 none 1 addr 2 target
1 1 0 5 2 0 00000000 00001000 0
1 1 0 0 0 0 00001000 00000000 0
1 1 0 0 1 0 00001004 00000000 0
1 1 0 0 0 0 0000100a 00000000 1
1 1 0 0 1 0 0000100e 00000000 0
2 1 1 5 2 0 00000000 00002000 0
2 1 1 1 0 0 00002000 00002100 0
2 1 1 0 0 0 00002104 00000000 1
2 1 1 2 0 1 00002108 00002200 0
2 1 1 0 0 0 00002204 00000000 1
2 1 1 2 1 0 00002208 00002300 0
2 1 1 0 0 0 0000220c 00000000 1
3 1 2 5 0 0 00000000 00008000 0
3 1 2 5 1 0 00000000 00003010 0
3 1 2 3 0 0 00003000 00008000 0
3 1 2 4 0 0 00008000 00003010 0
3 1 2 3 0 0 00003010 00008004 2
3 1 2 0 0 0 00008000 00000000 0
3 1 2 4 0 0 00008004 00003020 2
4 1 3 0 0 0 00004000 00000000 0
4 1 0 0 0 0 00001010 00000000 0
4 1 2 0 0 0 00003010 00000000 0
4 1 3 0 1 0 00004004 00000000 0
4 1 1 0 0 0 00002210 00000000 0
4 1 0 0 0 0 00001020 00000000 1
5 1 0 0 0 0 00001100 00000000 1
5 1 3 0 0 0 00004100 00000000 1
5 1 0 0 0 0 00001200 00000000 1
5 1 3 0 0 0 00004200 00000000 1
6 0 1 0 0 0 00009000 00000000 0
6 1 1 0 0 0 00005000 00000000 0
6 1 1 0 0 0 00005004 00000000 0
6 1 1 0 0 0 00005010 00000000 1

// File: tb/pc_check_tb.sv
// Testbench for the PC check top driving file records against random report stalls
`timescale 1ns/1ps
`default_nettype none

`include "pc_check_params.svh"

module pc_check_tb;

  logic                        clk;
  logic                        rst_n;
  logic                        enable;
  logic                        rec_valid;
  logic                        rec_ready;
  logic [`PC_HART_W-1:0]       rec_hart;
  pc_check_pkg::trace_rec_u    rec_data;
  logic                        rpt_valid;
  logic                        rpt_ready;
  logic [`PC_HART_W-1:0]       rpt_hart;
  pc_check_pkg::err_code_e     rpt_code;
  logic [`PC_XLEN-1:0]         rpt_pc;
  logic [`PC_NUM_HARTS-1:0]    err_flags;

  // Records from the data file
  int                          d_grp [$];
  logic                        d_en [$];
  logic [`PC_HART_W-1:0]       d_hart [$];
  logic [2:0]                  d_kind [$];
  logic [1:0]                  d_a [$];
  logic                        d_b [$];
  logic [`PC_XLEN-1:0]         d_pc [$];
  logic [`PC_XLEN-1:0]         d_tgt [$];
  logic [1:0]                  d_code [$];

  // Scoreboard of expected {code, pc} per hart
  logic [`PC_XLEN+1:0]         exp_q [`PC_NUM_HARTS][$];
  logic [`PC_NUM_HARTS-1:0]    exp_flags;
  int                          errors;
  int                          checks;
  integer                      seed;
  logic                        load_done;

  pc_check_top i_pc_check_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (enable),
    .rec_valid_i (rec_valid),
    .rec_ready_o (rec_ready),
    .rec_hart_i  (rec_hart),
    .rec_data_i  (rec_data),
    .rpt_valid_o (rpt_valid),
    .rpt_ready_i (rpt_ready),
    .rpt_hart_o  (rpt_hart),
    .rpt_code_o  (rpt_code),
    .rpt_pc_o    (rpt_pc),
    .err_flags_o (err_flags)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic load_records();
    int                    fd;
    int                    n;
    string                 line;
    int                    grp;
    logic                  en;
    logic [`PC_HART_W-1:0] hart;
    logic [2:0]            kind;
    logic [1:0]            fa;
    logic                  fb;
    logic [`PC_XLEN-1:0]   pc;
    logic [`PC_XLEN-1:0]   tgt;
    logic [1:0]            code;
    fd = $fopen("tb/pc_check_testdata.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = 0;
        // Skip column notes and blank lines
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%d %d %d %d %d %d %h %h %d",
                      grp, en, hart, kind, fa, fb, pc, tgt, code);
        end
        if (n == 9) begin
          d_grp.push_back(grp);
          d_en.push_back(en);
          d_hart.push_back(hart);
          d_kind.push_back(kind);
          d_a.push_back(fa);
          d_b.push_back(fb);
          d_pc.push_back(pc);
          d_tgt.push_back(tgt);
          d_code.push_back(code);
        end
      end
      $fclose(fd);
    end
  endtask

  // Kind 5 uses the CSR view, the rest the flow view
  function automatic pc_check_pkg::trace_rec_u build_rec(input logic [2:0] kind,
      input logic [1:0] fa, input logic fb, input logic [`PC_XLEN-1:0] pc,
      input logic [`PC_XLEN-1:0] tgt);
    pc_check_pkg::trace_rec_u rec;
    rec = '0;
    if (kind == 3'd5) begin
      rec.csr.kind    = pc_check_pkg::CSR_WR;
      rec.csr.csr_sel = pc_check_pkg::csr_sel_e'(fa);
      rec.csr.value   = tgt;
    end else begin
      rec.flow.kind       = pc_check_pkg::rec_kind_e'(kind);
      rec.flow.compressed = fa[0];
      rec.flow.taken      = fb;
      rec.flow.pc         = pc;
      rec.flow.target     = tgt;
    end
    return rec;
  endfunction

  // Entered 1 ns after a rising edge, returns at the same phase
  task automatic send_rec(input logic [`PC_HART_W-1:0] hart,
      input pc_check_pkg::trace_rec_u rec);
    logic accepted;
    rec_valid = 1'b1;
    rec_hart  = hart;
    rec_data  = rec;
    accepted  = 1'b0;
    while (!accepted) begin
      #1;
      accepted = rec_ready;
      @(posedge clk);
      #1;
    end
    rec_valid = 1'b0;
  endtask

  function automatic int pending_reports();
    int total;
    total = 0;
    for (int h = 0; h < `PC_NUM_HARTS; h++) begin
      total += exp_q[h].size();
    end
    return total;
  endfunction

  // Wait for outstanding reports, then let the pipeline settle
  task automatic drain_reports();
    int spins;
    spins = 0;
    while (pending_reports() != 0 && spins < 60) begin
      @(posedge clk);
      #1;
      spins++;
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic finish_group(input int grp, input int recs, input int start_err);
    drain_reports();
    checks++;
    // Sticky flags follow the harts that had any error so far
    assert (err_flags == exp_flags) else begin
      $display("FAILED at %0t: err_flags_o %b, expected %b", $time, err_flags, exp_flags);
      errors++;
    end
    $display("Group %0d done: %0d records, %0d errors", grp, recs, errors - start_err);
  endtask

  //////////////////////////////////////////////////
  // Report stalls and report checking
  //////////////////////////////////////////////////

  initial begin : stall_gen
    forever begin
      @(posedge clk);
      #1;
      // Ready about three cycles in four
      rpt_ready = ($random(seed) % 4) != 0;
    end
  end

  // Sample 1 ns before the edge that completes the transfer
  initial begin : report_monitor
    logic [`PC_XLEN+1:0]   head;
    logic [`PC_HART_W-1:0] h;
    forever begin
      @(posedge clk);
      #3;
      if (rst_n && rpt_valid && rpt_ready) begin
        h = rpt_hart;
        assert (exp_q[h].size() != 0) else begin
          $display("Unexpected report from hart %0d at %0t, no error was expected", h, $time);
          errors++;
        end
        if (exp_q[h].size() != 0) begin
          head = exp_q[h].pop_front();
          checks++;
          assert ((2'(rpt_code) == head[`PC_XLEN+1:`PC_XLEN]) &&
                  (rpt_pc == head[`PC_XLEN-1:0])) else begin
            $display("FAILED at %0t: hart %0d got code %0d pc %h, expected code %0d pc %h",
                     $time, h, rpt_code, rpt_pc, head[`PC_XLEN+1:`PC_XLEN],
                     head[`PC_XLEN-1:0]);
            errors++;
          end
        end
      end
    end
  end

  // 40 cycles per record plus reset and settling
  initial begin : watchdog
    wait (load_done);
    repeat (d_grp.size() * 40 + 50) @(posedge clk);
    $display("Watchdog expired: the run did not end within %0d cycles", d_grp.size() * 40 + 50);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main_seq
    int                  cur_grp;
    int                  grp_start;
    int                  grp_recs;
    logic [`PC_XLEN+1:0] head;
    rst_n     = 1'b0;
    enable    = 1'b1;
    rec_valid = 1'b0;
    rec_hart  = '0;
    rec_data  = '0;
    rpt_ready = 1'b0;
    exp_flags = '0;
    errors    = 0;
    checks    = 0;
    seed      = 32'hb31c_beb7;
    load_done = 1'b0;
    load_records();
    load_done = 1'b1;
    if (d_grp.size() == 0) begin
      $display("Test data file could not be read or holds no records");
      errors++;
    end else begin
      repeat (4) @(posedge clk);
      #1;
      rst_n     = 1'b1;
      cur_grp   = d_grp[0];
      grp_start = errors;
      grp_recs  = 0;
      for (int i = 0; i < d_grp.size(); i++) begin
        if (d_grp[i] != cur_grp) begin
          finish_group(cur_grp, grp_recs, grp_start);
          cur_grp   = d_grp[i];
          grp_start = errors;
          grp_recs  = 0;
        end
        // Enable is shared, so change it only with the pipeline empty
        if (d_en[i] != enable) begin
          drain_reports();
          if (d_en[i]) begin
            enable = 1'b1;
          end
        end
        if (d_code[i] != 2'd0) begin
          exp_q[d_hart[i]].push_back({d_code[i], d_pc[i]});
          exp_flags[d_hart[i]] = 1'b1;
        end
        send_rec(d_hart[i], build_rec(d_kind[i], d_a[i], d_b[i], d_pc[i], d_tgt[i]));
        // Enable drops in the cycle the lane takes the record with its PC still known
        if (!d_en[i]) begin
          enable = 1'b0;
        end
        grp_recs++;
      end
      finish_group(cur_grp, grp_recs, grp_start);
      // Anything left was never reported
      for (int h = 0; h < `PC_NUM_HARTS; h++) begin
        while (exp_q[h].size() != 0) begin
          head = exp_q[h].pop_front();
          $display("Missing report: hart %0d never reported code %0d at pc %h",
                   h, head[`PC_XLEN+1:`PC_XLEN], head[`PC_XLEN-1:0]);
          errors++;
        end
      end
    end
    $display("Records: %0d, checks: %0d, errors: %0d", d_grp.size(), checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/pc_check_top.sv
// PC hardening monitor top with router, per-hart check lanes and error collector
`timescale 1ns/1ps
`default_nettype none

`include "pc_check_params.svh"

module pc_check_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        enable_i,

  // Retirement record stream
  input  logic                        rec_valid_i,
  output logic                        rec_ready_o,
  input  logic [`PC_HART_W-1:0]       rec_hart_i,
  input  pc_check_pkg::trace_rec_u    rec_data_i,

  // Error reports
  output logic                        rpt_valid_o,
  input  logic                        rpt_ready_i,
  output logic [`PC_HART_W-1:0]       rpt_hart_o,
  output pc_check_pkg::err_code_e     rpt_code_o,
  output logic [`PC_XLEN-1:0]         rpt_pc_o,
  output logic [`PC_NUM_HARTS-1:0]    err_flags_o
);

  // Router to lanes
  logic [`PC_NUM_HARTS-1:0]   lane_valid;
  logic [`PC_NUM_HARTS-1:0]   lane_ready;
  pc_check_pkg::trace_rec_u   lane_rec;

  // Lanes to collector
  logic [`PC_NUM_HARTS-1:0]   err_valid;
  logic [`PC_NUM_HARTS-1:0]   err_ready;
  pc_check_pkg::err_code_e    err_code [`PC_NUM_HARTS];
  logic [`PC_XLEN-1:0]        err_pc [`PC_NUM_HARTS];

  pc_trace_router i_router (
    .clk          (clk),
    .rst_n        (rst_n),
    .rec_valid_i  (rec_valid_i),
    .rec_ready_o  (rec_ready_o),
    .rec_hart_i   (rec_hart_i),
    .rec_data_i   (rec_data_i),
    .lane_valid_o (lane_valid),
    .lane_ready_i (lane_ready),
    .lane_rec_o   (lane_rec)
  );

  // One lane per hart
  for (genvar k = 0; k < `PC_NUM_HARTS; k++) begin : g_lane
    pc_check_lane i_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .enable_i    (enable_i),
      .rec_valid_i (lane_valid[k]),
      .rec_ready_o (lane_ready[k]),
      .rec_i       (lane_rec),
      .err_valid_o (err_valid[k]),
      .err_ready_i (err_ready[k]),
      .err_code_o  (err_code[k]),
      .err_pc_o    (err_pc[k])
    );
  end

  pc_err_collector i_collector (
    .clk         (clk),
    .rst_n       (rst_n),
    .err_valid_i (err_valid),
    .err_ready_o (err_ready),
    .err_code_i  (err_code),
    .err_pc_i    (err_pc),
    .rpt_valid_o (rpt_valid_o),
    .rpt_ready_i (rpt_ready_i),
    .rpt_hart_o  (rpt_hart_o),
    .rpt_code_o  (rpt_code_o),
    .rpt_pc_o    (rpt_pc_o),
    .err_flags_o (err_flags_o)
  );

endmodule

`default_nettype wire

// File: src/pc_err_collector.sv
// Error collector that arbitrates lane error events into one report stream
`timescale 1ns/1ps
`default_nettype none

`include "pc_check_params.svh"

module pc_err_collector (
  input  logic                        clk,
  input  logic                        rst_n,

  // Lane error events
  input  logic [`PC_NUM_HARTS-1:0]    err_valid_i,
  output logic [`PC_NUM_HARTS-1:0]    err_ready_o,
  input  pc_check_pkg::err_code_e     err_code_i [`PC_NUM_HARTS],
  input  logic [`PC_XLEN-1:0]         err_pc_i [`PC_NUM_HARTS],

  // Report stream and sticky flags
  output logic                        rpt_valid_o,
  input  logic                        rpt_ready_i,
  output logic [`PC_HART_W-1:0]       rpt_hart_o,
  output pc_check_pkg::err_code_e     rpt_code_o,
  output logic [`PC_XLEN-1:0]         rpt_pc_o,
  output logic [`PC_NUM_HARTS-1:0]    err_flags_o
);

  logic [`PC_HART_W-1:0]      rr_ptr_q;
  logic                       rpt_valid_q;
  logic [`PC_HART_W-1:0]      rpt_hart_q;
  pc_check_pkg::err_code_e    rpt_code_q;
  logic [`PC_XLEN-1:0]        rpt_pc_q;
  logic [`PC_NUM_HARTS-1:0]   err_flags_q;

  logic                       rpt_free;
  logic                       sel_found;
  logic [`PC_HART_W-1:0]      sel_hart;
  logic                       take;

  // Report register free when empty or being taken
  assign rpt_free = !rpt_valid_q || rpt_ready_i;

  //////////////////////////////////////////////////
  // Round-robin pick starting at rr_ptr_q
  //////////////////////////////////////////////////

  always_comb begin
    logic [`PC_HART_W-1:0] cand;
    sel_found = 1'b0;
    sel_hart  = rr_ptr_q;
    for (int i = 0; i < `PC_NUM_HARTS; i++) begin
      cand = rr_ptr_q + `PC_HART_W'(i);
      if (!sel_found && err_valid_i[cand]) begin
        sel_found = 1'b1;
        sel_hart  = cand;
      end
    end
  end

  assign take = rpt_free && sel_found;

  always_comb begin
    err_ready_o = '0;
    if (take) begin
      err_ready_o[sel_hart] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr_q    <= '0;
      rpt_valid_q <= 1'b0;
      err_flags_q <= '0;
    end else if (take) begin
      rpt_valid_q           <= 1'b1;
      err_flags_q[sel_hart] <= 1'b1;
      // Winner goes to the back of the line
      rr_ptr_q              <= sel_hart + 1'b1;
    end else if (rpt_ready_i) begin
      rpt_valid_q <= 1'b0;
    end
  end

  // Report payload
  always_ff @(posedge clk) begin
    if (take) begin
      rpt_hart_q <= sel_hart;
      rpt_code_q <= err_code_i[sel_hart];
      rpt_pc_q   <= err_pc_i[sel_hart];
    end
  end

  assign rpt_valid_o = rpt_valid_q;
  assign rpt_hart_o  = rpt_hart_q;
  assign rpt_code_o  = rpt_code_q;
  assign rpt_pc_o    = rpt_pc_q;
  assign err_flags_o = err_flags_q;

endmodule

`default_nettype wire

// File: src/pc_check_lane.sv
// Per-hart PC check lane tracking the expected PC and trap CSRs to flag errors
`timescale 1ns/1ps
`default_nettype none

`include "pc_check_params.svh"

module pc_check_lane (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        enable_i,

  // Records from the router
  input  logic                        rec_valid_i,
  output logic                        rec_ready_o,
  input  pc_check_pkg::trace_rec_u    rec_i,

  // Error event to the collector
  output logic                        err_valid_o,
  input  logic                        err_ready_i,
  output pc_check_pkg::err_code_e     err_code_o,
  output logic [`PC_XLEN-1:0]         err_pc_o
);

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  logic [`PC_XLEN-1:0]      exp_pc_q;
  logic                     known_q;
  logic [`PC_XLEN-1:0]      mtvec_q;
  logic [`PC_XLEN-1:0]      mepc_q;
  logic                     err_valid_q;
  pc_check_pkg::err_code_e  err_code_q;
  logic [`PC_XLEN-1:0]      err_pc_q;

  logic                     rec_accept;
  logic                     is_csr;
  logic [`PC_XLEN-1:0]      seq_pc;
  logic [`PC_XLEN-1:0]      next_pc;
  logic                     addr_err;
  logic                     tgt_err;
  pc_check_pkg::err_code_e  rec_code;

  // Stall new records while an event waits
  assign rec_ready_o = !err_valid_q;
  assign rec_accept  = rec_valid_i && rec_ready_o;
  assign is_csr      = (rec_i.flow.kind == pc_check_pkg::CSR_WR);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Mismatch against tracked PC, skipped until a PC is known
  assign addr_err = enable_i && !is_csr && known_q && (rec_i.flow.pc != exp_pc_q);

  // Trap and mret must land on the CSR copy
  assign tgt_err = enable_i &&
                   (((rec_i.flow.kind == pc_check_pkg::TRAP) && (rec_i.flow.target != mtvec_q)) ||
                    ((rec_i.flow.kind == pc_check_pkg::MRET) && (rec_i.flow.target != mepc_q)));

  // ADDR wins over TARGET
  assign rec_code = addr_err ? pc_check_pkg::ADDR   :
                    tgt_err  ? pc_check_pkg::TARGET : pc_check_pkg::NONE;

  //////////////////////////////////////////////////
  // Next PC
  //////////////////////////////////////////////////

  // Fall-through by instruction length
  assign seq_pc = rec_i.flow.pc + (rec_i.flow.compressed ? `PC_XLEN'(2) : `PC_XLEN'(4));

  always_comb begin
    next_pc = seq_pc;
    case (rec_i.flow.kind)
      pc_check_pkg::JUMP:   next_pc = rec_i.flow.target;
      pc_check_pkg::BRANCH: begin
        if (rec_i.flow.taken) begin
          next_pc = rec_i.flow.target;
        end
      end
      // Redirect to CSR copy even when the reported target is off
      pc_check_pkg::TRAP:   next_pc = mtvec_q;
      pc_check_pkg::MRET:   next_pc = mepc_q;
      default:              next_pc = seq_pc;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      known_q     <= 1'b0;
      mtvec_q     <= '0;
      mepc_q      <= '0;
      err_valid_q <= 1'b0;
    end else begin
      if (err_valid_q && err_ready_i) begin
        err_valid_q <= 1'b0;
      end
      if (rec_accept) begin
        if (is_csr) begin
          case (rec_i.csr.csr_sel)
            pc_check_pkg::MTVEC:   mtvec_q <= rec_i.csr.value;
            pc_check_pkg::MEPC:    mepc_q  <= rec_i.csr.value;
            pc_check_pkg::RESTART: known_q <= 1'b1;
            default:               ;
          endcase
        end else begin
          // First flow record after enable only seeds the tracker
          known_q <= 1'b1;
        end
        if (rec_code != pc_check_pkg::NONE) begin
          err_valid_q <= 1'b1;
        end
      end
      // Disabled lane forgets its PC
      if (!enable_i) begin
        known_q <= 1'b0;
      end
    end
  end

  // Expected PC and event payload
  always_ff @(posedge clk) begin
    if (rec_accept) begin
      if (!is_csr) begin
        exp_pc_q <= next_pc;
      end else if (rec_i.csr.csr_sel == pc_check_pkg::RESTART) begin
        exp_pc_q <= rec_i.csr.value;
      end
      if (rec_code != pc_check_pkg::NONE) begin
        err_code_q <= rec_code;
        err_pc_q   <= rec_i.flow.pc;
      end
    end
  end

  assign err_valid_o = err_valid_q;
  assign err_code_o  = err_code_q;
  assign err_pc_o    = err_pc_q;

endmodule

`default_nettype wire

// File: src/pc_trace_router.sv
// Trace router that registers each retirement record and steers it to its hart lane
`timescale 1ns/1ps
`default_nettype none

`include "pc_check_params.svh"

module pc_trace_router (
  input  logic                        clk,
  input  logic                        rst_n,

  // Record input stream
  input  logic                        rec_valid_i,
  output logic                        rec_ready_o,
  input  logic [`PC_HART_W-1:0]       rec_hart_i,
  input  pc_check_pkg::trace_rec_u    rec_data_i,

  // Per-lane streams, record bus shared
  output logic [`PC_NUM_HARTS-1:0]    lane_valid_o,
  input  logic [`PC_NUM_HARTS-1:0]    lane_ready_i,
  output pc_check_pkg::trace_rec_u    lane_rec_o
);

  // Slot state
  logic                       slot_valid_q;
  logic [`PC_HART_W-1:0]      slot_hart_q;
  pc_check_pkg::trace_rec_u   slot_rec_q;

  logic                       slot_drain;
  logic                       rec_accept;

  // Slot empties when its addressed lane takes it
  assign slot_drain  = slot_valid_q && lane_ready_i[slot_hart_q];
  // Refill allowed while draining in the same cycle
  assign rec_ready_o = !slot_valid_q || slot_drain;
  assign rec_accept  = rec_valid_i && rec_ready_o;

  // One-hot steering from the stored hart id
  always_comb begin
    lane_valid_o = '0;
    if (slot_valid_q) begin
      lane_valid_o[slot_hart_q] = 1'b1;
    end
  end

  assign lane_rec_o = slot_rec_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid_q <= 1'b0;
    end else if (rec_accept) begin
      slot_valid_q <= 1'b1;
    end else if (slot_drain) begin
      slot_valid_q <= 1'b0;
    end
  end

  // Slot payload
  always_ff @(posedge clk) begin
    if (rec_accept) begin
      slot_hart_q <= rec_hart_i;
      slot_rec_q  <= rec_data_i;
    end
  end

endmodule

`default_nettype wire

// File: src/pc_check_pkg.sv
// PC check package with record kinds, CSR selectors, error codes and record layouts
`default_nettype none

`include "pc_check_params.svh"

package pc_check_pkg;

  // Record kind, top 3 bits of every record
  typedef enum logic [2:0] {
    SEQ    = 3'd0,
    JUMP   = 3'd1,
    BRANCH = 3'd2,
    TRAP   = 3'd3,
    MRET   = 3'd4,
    CSR_WR = 3'd5
  } rec_kind_e;

  // CSR targeted by a CSR_WR record
  typedef enum logic [1:0] {
    MTVEC   = 2'd0,
    MEPC    = 2'd1,
    RESTART = 2'd2
  } csr_sel_e;

  // Error classes reported by a lane
  typedef enum logic [1:0] {
    NONE   = 2'd0,
    ADDR   = 2'd1,
    TARGET = 2'd2
  } err_code_e;

  // Control flow view, 72 bits
  typedef struct packed {
    rec_kind_e            kind;
    logic                 compressed;
    logic                 taken;
    logic [2:0]           pad0;
    logic [`PC_XLEN-1:0]  pc;
    logic [`PC_XLEN-1:0]  target;
  } flow_rec_t;

  // CSR update view, 72 bits, kind overlays the flow kind
  typedef struct packed {
    rec_kind_e            kind;
    csr_sel_e             csr_sel;
    logic [2:0]           pad0;
    logic [`PC_XLEN-1:0]  pad1;
    logic [`PC_XLEN-1:0]  value;
  } csr_rec_t;

  // One record word, kind picks the view
  typedef union packed {
    flow_rec_t flow;
    csr_rec_t  csr;
  } trace_rec_u;

endpackage

`default_nettype wire

// File: include/pc_check_params.svh
// PC check sizing macros shared by the package and all checker modules
`ifndef PC_CHECK_PARAMS_SVH
`define PC_CHECK_PARAMS_SVH

//////////////////////////////////////////////////
// Cluster size
//////////////////////////////////////////////////

// Number of harts, one checking lane each
`define PC_NUM_HARTS 4

// Hart id width, must cover PC_NUM_HARTS
`define PC_HART_W 2

//////////////////////////////////////////////////
// Address size
//////////////////////////////////////////////////

// RV32 address width
`define PC_XLEN 32

`endif
